// File: common/display_pkg.sv
`default_nettype none

package display_pkg;

    localparam int MAX_DIM = 7;                 // largest row or column count

    typedef logic [7:0] ascii_t;
    typedef logic signed [7:0] elem_t;
    typedef logic [$clog2(MAX_DIM + 1)-1:0] dim_t;
    typedef logic [3:0] matrix_id_t;
    typedef logic [$clog2(MAX_DIM * MAX_DIM + 1)-1:0] elem_count_t;
    typedef logic [4:0] title_idx_t;

    typedef enum logic [1:0] {
        MODE_MATRIX = 2'd0,
        MODE_LIST   = 2'd1,                     // not supported, start is ignored
        MODE_RESULT = 2'd2
    } display_mode_e;

    typedef struct packed {
        matrix_id_t id;
        dim_t       m;                          // rows
        dim_t       n;                          // columns
    } matrix_info_t;

    // one element as characters, flags tell which leading chars exist
    typedef struct packed {
        logic   negative;
        logic   has_hundreds;
        logic   has_tens;
        ascii_t hundreds;
        ascii_t tens;
        ascii_t ones;
    } digits_t;

    localparam ascii_t CH_SPACE   = 8'h20;
    localparam ascii_t CH_NEWLINE = 8'h0a;
    localparam ascii_t CH_MINUS   = 8'h2d;
    localparam ascii_t CH_ZERO    = 8'h30;
    localparam ascii_t CH_X       = 8'h78;      // lower case x between m and n
    localparam ascii_t CH_LPAREN  = 8'h28;
    localparam ascii_t CH_RPAREN  = 8'h29;
    localparam ascii_t CH_COLON   = 8'h3a;

    // leading word of each title, first character in the top byte
    localparam logic [47:0] WORD_MATRIX = "Matrix";
    localparam logic [47:0] WORD_RESULT = "Result";

    localparam int TITLE_MATRIX_LEN = 16;       // "Matrix I (MxN):\n"
    localparam int TITLE_RESULT_LEN = 14;       // "Result (MxN):\n"

endpackage

`default_nettype wire

// File: hw/title_builder.sv
`default_nettype none
`timescale 1ns/1ps

module title_builder import display_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          latch,
    input  wire display_mode_e mode,
    input  wire matrix_info_t  info_in,
    input  wire title_idx_t    idx,
    output matrix_info_t       info,
    output ascii_t             title_char,
    output logic               title_end
);

    display_mode_e mode_q;
    logic          is_matrix;
    logic [2:0]    tail_idx;
    logic [47:0]   word_sel;
    ascii_t        tail_char;
    title_idx_t    title_len;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= MODE_MATRIX;
            info   <= '0;
        end else if (latch) begin
            mode_q <= mode;
            info   <= info_in;
        end
    end

    assign is_matrix = (mode_q == MODE_MATRIX);
    assign word_sel  = is_matrix ? WORD_MATRIX : WORD_RESULT;

    assign title_len = is_matrix ? title_idx_t'(TITLE_MATRIX_LEN)
                                 : title_idx_t'(TITLE_RESULT_LEN);
    assign title_end = (idx == title_len);

    // both titles end in " (MxN):\n", matrix has " I" in front of it
    assign tail_idx = is_matrix ? 3'(idx - 5'd8) : 3'(idx - 5'd6);

    always_comb begin
        case (tail_idx)
            3'd0:    tail_char = CH_SPACE;
            3'd1:    tail_char = CH_LPAREN;
            3'd2:    tail_char = CH_ZERO + ascii_t'(info.m);
            3'd3:    tail_char = CH_X;
            3'd4:    tail_char = CH_ZERO + ascii_t'(info.n);
            3'd5:    tail_char = CH_RPAREN;
            3'd6:    tail_char = CH_COLON;
            default: tail_char = CH_NEWLINE;
        endcase
    end

    always_comb begin
        if (idx < 5'd6) begin
            title_char = word_sel[47 - 8 * idx -: 8];   // leading word
        end else if (is_matrix && idx == 5'd6) begin
            title_char = CH_SPACE;
        end else if (is_matrix && idx == 5'd7) begin
            // ids above 9 leave the digit range
            title_char = CH_ZERO + ascii_t'(info.id);
        end else begin
            title_char = tail_char;
        end
    end

endmodule

`default_nettype wire

// File: hw/element_counter.sv
`default_nettype none
`timescale 1ns/1ps

module element_counter import display_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic clear,
    input  wire logic step,
    input  wire dim_t m,
    input  wire dim_t n,
    output logic      row_end,
    output logic      last,
    output logic      empty
);

    dim_t        col;
    elem_count_t count;                     // elements already printed
    elem_count_t total;

    assign total = elem_count_t'(m) * elem_count_t'(n);
    assign empty = (total == '0);

    // n - 1 wraps for n == 0, but then empty already holds
    assign row_end = (col == n - 3'd1);
    assign last    = (count == total - 6'd1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col   <= '0;
            count <= '0;
        end else if (clear) begin
            col   <= '0;
            count <= '0;
        end else if (step) begin
            count <= count + 6'd1;
            col   <= row_end ? '0 : col + 3'd1;   // wrap at row end
        end
    end

endmodule

`default_nettype wire

// File: hw/signed_decimal_ascii.sv
`default_nettype none
`timescale 1ns/1ps

module signed_decimal_ascii import display_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  load,
    input  wire elem_t elem_in,
    output digits_t    digits
);

    elem_t      elem_q;
    logic [7:0] mag;                        // 0..128
    logic [7:0] hund_val;
    logic [7:0] tens_val;
    logic [7:0] ones_val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            elem_q <= '0;
        end else if (load) begin
            elem_q <= elem_in;
        end
    end

    // two's complement negate, -128 gives 8'h80
    assign mag = elem_q[7] ? (~elem_q + 8'd1) : elem_q;

    assign hund_val = mag / 8'd100;
    assign tens_val = (mag / 8'd10) % 8'd10;
    assign ones_val = mag % 8'd10;

    always_comb begin
        digits.negative     = elem_q[7];
        digits.has_hundreds = (mag >= 8'd100);
        digits.has_tens     = (mag >= 8'd10);   // also set for 100..128
        digits.hundreds     = CH_ZERO + hund_val;
        digits.tens         = CH_ZERO + tens_val;
        digits.ones         = CH_ZERO + ones_val;
    end

endmodule

`default_nettype wire

// File: hw/format_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module format_fsm import display_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          start_format,
    input  wire display_mode_e display_mode,
    input  wire logic          matrix_data_valid,
    input  wire logic          tx_busy,
    input  wire ascii_t        title_char,
    input  wire logic          title_end,
    input  wire digits_t       digits,
    input  wire logic          row_end,
    input  wire logic          last,
    input  wire logic          empty,
    output title_idx_t         title_idx,
    output logic               latch_info,
    output logic               load_elem,
    output logic               count_step,
    output logic               count_clear,
    output ascii_t             tx_data,
    output logic               tx_valid,
    output logic               data_req,
    output logic               format_done
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_TITLE,
        ST_FETCH,                           // waiting for matrix_data_valid
        ST_SIGN,
        ST_HUNDREDS,
        ST_TENS,
        ST_ONES,
        ST_SEP,                             // space or row newline
        ST_FINAL_NL,
        ST_DONE
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   start_ok;
    logic   can_send;
    logic   send;                           // character leaves this cycle
    logic   req_nxt;
    ascii_t char_sel;

    assign start_ok = (state == ST_IDLE) && start_format &&
                      (display_mode == MODE_MATRIX || display_mode == MODE_RESULT);

    // tx_valid high means a char went out last cycle, the sink
    // gets this cycle to raise tx_busy
    assign can_send = !tx_busy && !tx_valid;

    assign latch_info  = start_ok;
    assign count_clear = start_ok;
    assign load_elem   = (state == ST_FETCH) && matrix_data_valid;
    assign count_step  = (state == ST_SEP) && can_send;

    always_comb begin
        state_nxt = state;
        send      = 1'b0;
        req_nxt   = 1'b0;
        char_sel  = CH_NEWLINE;
        case (state)
            ST_IDLE: begin
                if (start_ok) state_nxt = ST_TITLE;
            end
            ST_TITLE: begin
                char_sel = title_char;
                if (title_end) begin
                    if (empty) begin
                        state_nxt = ST_FINAL_NL;    // no elements, just close
                    end else begin
                        req_nxt   = 1'b1;
                        state_nxt = ST_FETCH;
                    end
                end else if (can_send) begin
                    send = 1'b1;
                end
            end
            ST_FETCH: begin
                if (matrix_data_valid) state_nxt = ST_SIGN;
            end
            ST_SIGN: begin
                char_sel = CH_MINUS;
                if (!digits.negative) begin
                    state_nxt = ST_HUNDREDS;
                end else if (can_send) begin
                    send      = 1'b1;
                    state_nxt = ST_HUNDREDS;
                end
            end
            ST_HUNDREDS: begin
                char_sel = digits.hundreds;
                if (!digits.has_hundreds) begin
                    state_nxt = ST_TENS;
                end else if (can_send) begin
                    send      = 1'b1;
                    state_nxt = ST_TENS;
                end
            end
            ST_TENS: begin
                char_sel = digits.tens;
                if (!digits.has_tens) begin
                    state_nxt = ST_ONES;
                end else if (can_send) begin
                    send      = 1'b1;
                    state_nxt = ST_ONES;
                end
            end
            ST_ONES: begin
                char_sel = digits.ones;     // always printed
                if (can_send) begin
                    send      = 1'b1;
                    state_nxt = ST_SEP;
                end
            end
            ST_SEP: begin
                char_sel = row_end ? CH_NEWLINE : CH_SPACE;
                if (can_send) begin
                    send = 1'b1;
                    if (last) begin
                        state_nxt = ST_FINAL_NL;
                    end else begin
                        req_nxt   = 1'b1;
                        state_nxt = ST_FETCH;
                    end
                end
            end
            ST_FINAL_NL: begin
                if (can_send) begin
                    send      = 1'b1;
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            title_idx   <= '0;
            tx_valid    <= 1'b0;
            data_req    <= 1'b0;
            format_done <= 1'b0;
        end else begin
            state       <= state_nxt;
            tx_valid    <= send;
            data_req    <= req_nxt;
            format_done <= (state == ST_DONE);  // one cycle after last tx_valid
            if (start_ok) begin
                title_idx <= '0;
            end else if (send && state == ST_TITLE) begin
                title_idx <= title_idx + 5'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) tx_data <= char_sel;
    end

endmodule

`default_nettype wire

// File: hw/display_formatter.sv
`default_nettype none
`timescale 1ns/1ps

module display_formatter import display_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          start_format,
    input  wire display_mode_e display_mode,
    input  wire matrix_info_t  info,
    input  wire elem_t         matrix_data,
    input  wire logic          matrix_data_valid,
    input  wire logic          tx_busy,
    output ascii_t             tx_data,
    output logic               tx_valid,
    output logic               data_req,
    output logic               format_done
);

    // fsm to title builder
    title_idx_t   title_idx;
    ascii_t       title_char;
    logic         title_end;
    logic         latch_info;

    // fsm to element counter
    logic         count_step;
    logic         count_clear;
    logic         row_end;
    logic         last;
    logic         empty;

    logic         load_elem;
    digits_t      digits;
    matrix_info_t info_q;                   // info held for the whole run

    format_fsm i_format_fsm (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_format      (start_format),
        .display_mode      (display_mode),
        .matrix_data_valid (matrix_data_valid),
        .tx_busy           (tx_busy),
        .title_char        (title_char),
        .title_end         (title_end),
        .digits            (digits),
        .row_end           (row_end),
        .last              (last),
        .empty             (empty),
        .title_idx         (title_idx),
        .latch_info        (latch_info),
        .load_elem         (load_elem),
        .count_step        (count_step),
        .count_clear       (count_clear),
        .tx_data           (tx_data),
        .tx_valid          (tx_valid),
        .data_req          (data_req),
        .format_done       (format_done)
    );

    title_builder i_title_builder (
        .clk        (clk),
        .rst_n      (rst_n),
        .latch      (latch_info),
        .mode       (display_mode),
        .info_in    (info),
        .idx        (title_idx),
        .info       (info_q),
        .title_char (title_char),
        .title_end  (title_end)
    );

    element_counter i_element_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .clear   (count_clear),
        .step    (count_step),
        .m       (info_q.m),
        .n       (info_q.n),
        .row_end (row_end),
        .last    (last),
        .empty   (empty)
    );

    signed_decimal_ascii i_signed_decimal_ascii (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load_elem),
        .elem_in (matrix_data),
        .digits  (digits)
    );

endmodule

`default_nettype wire

// File: testbench/display_formatter_tb.sv
`default_nettype none
`timescale 1ns/1ps

module display_formatter_tb import display_pkg::*; ();

    logic          clk;
    logic          rst_n;
    logic          start_format;
    display_mode_e display_mode;
    matrix_info_t  info;
    elem_t         matrix_data;
    logic          matrix_data_valid;
    logic          tx_busy;
    ascii_t        tx_data;
    logic          tx_valid;
    logic          data_req;
    logic          format_done;

    // one entry per line of the test file
    int t_mode[$];
    int t_id[$];
    int t_m[$];
    int t_n[$];
    int t_busy[$];

    ascii_t exp_q[$];                       // characters still expected
    elem_t  src_q[$];                       // elements the source still hands out
    elem_t  corners [4] = '{8'h80, 8'hff, 8'h00, 8'h7f};   // -128, -1, 0, 127

    int   busy_left;
    int   busy_max;
    int   src_delay;
    int   req_count;
    int   chars_seen;
    int   cycles;
    int   cycle_limit;
    logic done_allowed;
    logic prev_valid;

    display_formatter i_display_formatter (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_format      (start_format),
        .display_mode      (display_mode),
        .info              (info),
        .matrix_data       (matrix_data),
        .matrix_data_valid (matrix_data_valid),
        .tx_busy           (tx_busy),
        .tx_data           (tx_data),
        .tx_valid          (tx_valid),
        .data_req          (data_req),
        .format_done       (format_done)
    );

    always #10 clk = ~clk;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_char(input string name, input ascii_t expected, input ascii_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error at %0t ns: %s expected 0x%02h got 0x%02h",
                                        $time, name, expected, actual));
        end
    endtask

    // done is only correct once every expected character went out
    task automatic check_done(input int remaining);
        if (remaining != 0) begin
            stop_with_failure($sformatf(
                "error at %0t ns: chars pending at format_done expected 0 got %0d",
                $time, remaining));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            stop_with_failure($sformatf("error at %0t ns: %s expected %0d got %0d",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic push_text(input string s);
        for (int k = 0; k < s.len(); k++) begin
            exp_q.push_back(ascii_t'(s[k]));
        end
    endtask

    // samples the outputs and then drives sink, source and strobes
    task automatic advance_cycle();
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > cycle_limit) begin
            stop_with_failure("timeout, the formatter did not finish within the cycle limit");
        end
        start_format = 1'b0;
        if (tx_valid) begin
            if (tx_busy) stop_with_failure("tx_valid rose while tx_busy was high");
            if (prev_valid) stop_with_failure("two characters sent in back to back cycles");
            if (exp_q.size() == 0) stop_with_failure("unexpected character on tx_data");
            check_char("tx_data", exp_q.pop_front(), tx_data);
            chars_seen++;
            busy_left = $urandom_range(busy_max, 0);
        end
        prev_valid = tx_valid;
        if (busy_left > 0) begin
            tx_busy = 1'b1;
            busy_left--;
        end else begin
            tx_busy = 1'b0;
        end
        matrix_data_valid = 1'b0;
        if (src_delay > 0) begin
            src_delay--;
            if (src_delay == 0) begin
                matrix_data       = src_q.pop_front();
                matrix_data_valid = 1'b1;
            end
        end
        if (data_req) begin
            if (src_q.size() == 0 || src_delay > 0) begin
                stop_with_failure("data_req without an element left to fetch");
            end
            req_count++;
            src_delay = $urandom_range(3, 1);   // answer 1 to 3 cycles later
        end
        if (format_done) begin
            if (!done_allowed) stop_with_failure("format_done pulsed outside a run");
            check_done(exp_q.size());
            done_allowed = 1'b0;
        end
    endtask

    task automatic run_test(input int idx);
        int    mode;
        int    total;
        logic  active;
        logic  restarted;
        elem_t value;
        mode       = t_mode[idx];
        total      = t_m[idx] * t_n[idx];
        active     = (mode == 0 || mode == 2);
        restarted  = 1'b0;
        busy_max   = t_busy[idx];
        busy_left  = 0;
        req_count  = 0;
        chars_seen = 0;
        exp_q.delete();
        src_q.delete();
        if (mode == 0) begin
            push_text("Matrix ");
            exp_q.push_back(ascii_t'(8'h30 + t_id[idx]));
            push_text(" (");
        end else if (mode == 2) begin
            push_text("Result (");
        end
        if (active) begin
            push_text($sformatf("%0dx%0d):", t_m[idx], t_n[idx]));
            exp_q.push_back(8'h0a);
            for (int i = 0; i < total; i++) begin
                value = elem_t'($urandom_range(255, 0));
                if (idx == 0 && i < 4) value = corners[i];
                src_q.push_back(value);
                push_text($sformatf("%0d", value));
                exp_q.push_back((i % t_n[idx] == t_n[idx] - 1) ? 8'h0a : 8'h20);
            end
            exp_q.push_back(8'h0a);             // closing blank line
        end
        display_mode = display_mode_e'(mode[1:0]);
        info.id      = matrix_id_t'(t_id[idx]);
        info.m       = dim_t'(t_m[idx]);
        info.n       = dim_t'(t_n[idx]);
        start_format = 1'b1;
        done_allowed = active;
        if (!active) begin
            repeat (20) advance_cycle();
        end else begin
            while (done_allowed) begin
                advance_cycle();
                if (chars_seen == 1 && !restarted) begin
                    // a start in the middle of a run must change nothing
                    restarted    = 1'b1;
                    display_mode = MODE_MATRIX;
                    info         = matrix_info_t'(~info);
                    start_format = 1'b1;
                end
            end
            repeat (3) advance_cycle();         // nothing may follow done
        end
        check_count("data_req count", active ? total : 0, req_count);
    endtask

    initial begin
        int    fd;
        int    fields;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        string line;
        clk               = 1'b0;
        rst_n             = 1'b0;
        start_format      = 1'b0;
        display_mode      = MODE_MATRIX;
        info              = '0;
        matrix_data       = '0;
        matrix_data_valid = 1'b0;
        tx_busy           = 1'b0;
        busy_left         = 0;
        busy_max          = 0;
        src_delay         = 0;
        req_count         = 0;
        chars_seen        = 0;
        cycles            = 0;
        cycle_limit       = 0;
        done_allowed      = 1'b0;
        prev_valid        = 1'b0;
        void'($urandom(32'h219c_1da9));

        fd = $fopen("testbench/display_formatter_tests.txt", "r");
        if (fd == 0) stop_with_failure("cannot open the test file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%d %d %d %d %d", a, b, c, d, e);
            if (line.len() > 0 && line[0] != "#" && fields == 5) begin
                t_mode.push_back(a);
                t_id.push_back(b);
                t_m.push_back(c);
                t_n.push_back(d);
                t_busy.push_back(e);
            end
        end
        $fclose(fd);
        if (t_mode.size() == 0) stop_with_failure("the test file holds no tests");

        foreach (t_mode[i]) begin
            cycle_limit += (t_m[i] * t_n[i] * 5 + 20) * (t_busy[i] + 4) + 100;
        end

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (tx_valid || data_req || format_done) begin
            stop_with_failure("outputs not low after reset");
        end

        foreach (t_mode[i]) begin
            run_test(i);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
common/display_pkg.sv
hw/title_builder.sv
hw/element_counter.sv
hw/signed_decimal_ascii.sv
hw/format_fsm.sv
hw/display_formatter.sv
testbench/display_formatter_tb.sv

// File: testbench/display_formatter_tests.txt
# columns: mode id m n busy_max (decimal)
# mode 0 matrix, 2 result, 1 and 3 are ignored starts
0 3 2 3 2
2 0 3 3 0
0 9 1 1 1
2 5 7 7 3
0 0 0 4 2
1 2 2 2 1
2 7 4 0 0
0 4 7 1 4
3 1 3 3 2
0 8 1 7 0
2 1 5 6 5
0 2 3 2 1
